// ==== src/rvPkg.sv ====
// Shared types, opcode and ALU enums, and sizing constants for the RV32I core
package rvPkg;

    // Sizing
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;

    // Data word for registers, ALU results and memory
    typedef logic [XLEN-1:0] xlenT;

    // Raw instruction word
    typedef logic [31:0] instrT;

    // Instruction fields
    typedef logic [4:0] regIdxT;
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;

    // Word index into the data memory
    typedef logic [DMEM_AW-1:0] dmemAddrT;

    // Supported major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeE;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } aluOpE;

    // Branch funct3 codes
    localparam funct3T F3_BEQ  = 3'b000;
    localparam funct3T F3_BNE  = 3'b001;
    localparam funct3T F3_BLT  = 3'b100;
    localparam funct3T F3_BGE  = 3'b101;
    localparam funct3T F3_BLTU = 3'b110;
    localparam funct3T F3_BGEU = 3'b111;

endpackage

// ==== src/instrDecode.sv ====
// Instruction register, field split, immediate generation and control decode
`timescale 1ns/1ps

module instrDecode import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instrValid,
    input  instrT   instr,
    input  xlenT    instrPc,
    input  logic    flush,
    output logic    decValid,
    output xlenT    pc,
    output regIdxT  rs1,
    output regIdxT  rs2,
    output regIdxT  rd,
    output funct3T  funct3,
    output xlenT    imm,
    output aluOpE   aluOp,
    output logic    aluSrcImm,
    output logic    aluSrcPc,
    output logic    regWrite,
    output logic    memRead,
    output logic    memWrite,
    output logic    isBranch,
    output logic    isJump,
    output logic    isJalr,
    output logic    illegalOp
);

    instrT  instrQ;
    logic   validQ;
    opcodeE opcode;
    funct7T funct7;
    xlenT   immI;
    xlenT   immS;
    xlenT   immB;
    xlenT   immU;
    xlenT   immJ;

    // Map funct3 plus the alternate bit onto an ALU operation
    function automatic aluOpE aluFromFunct(input funct3T f3, input logic alt);
        aluOpE op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Instruction register, an all-zero word decodes as illegal
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instrQ <= '0;
            validQ <= 1'b0;
        end
        else
        begin
            validQ <= instrValid;
            if (instrValid)
            begin
                instrQ <= instr;
            end
        end
    end

    // PC travels alongside the instruction
    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            pc <= instrPc;
        end
    end

    // Younger instruction dies while a redirect is pending
    assign decValid = validQ && !flush;

    // Field split
    assign opcode = opcodeE'(instrQ[6:0]);
    assign rd     = instrQ[11:7];
    assign funct3 = instrQ[14:12];
    assign rs1    = instrQ[19:15];
    assign rs2    = instrQ[24:20];
    assign funct7 = instrQ[31:25];

    // Sign-extended immediates per format
    assign immI = {{20{instrQ[31]}}, instrQ[31:20]};
    assign immS = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};
    assign immB = {{19{instrQ[31]}}, instrQ[31], instrQ[7], instrQ[30:25], instrQ[11:8], 1'b0};
    assign immU = {instrQ[31:12], 12'b0};
    assign immJ = {{11{instrQ[31]}}, instrQ[31], instrQ[19:12], instrQ[20], instrQ[30:21], 1'b0};

    // Control decode
    always_comb
    begin
        imm       = immI;
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        aluSrcPc  = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        isJalr    = 1'b0;
        illegalOp = 1'b0;
        case (opcode)
            OPC_LUI:
            begin
                imm       = immU;
                aluOp     = ALU_PASSB;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            OPC_AUIPC:
            begin
                imm       = immU;
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                regWrite  = 1'b1;
            end
            OPC_JAL:
            begin
                // ALU forms pc + imm as the target
                imm       = immJ;
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                regWrite  = 1'b1;
                isJump    = 1'b1;
            end
            OPC_JALR:
            begin
                // ALU forms rs1 + imm as the target
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                isJump    = 1'b1;
                isJalr    = 1'b1;
            end
            OPC_BRANCH:
            begin
                imm      = immB;
                isBranch = 1'b1;
            end
            OPC_LOAD:
            begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                memRead   = 1'b1;
            end
            OPC_STORE:
            begin
                imm       = immS;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            OPC_OPIMM:
            begin
                // Only SRAI uses funct7 as an alternate bit
                aluOp     = aluFromFunct(funct3, (funct3 == 3'b101) && funct7[5]);
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            OPC_OP:
            begin
                aluOp    = aluFromFunct(funct3, funct7[5]);
                regWrite = 1'b1;
            end
            default:
            begin
                illegalOp = 1'b1;
            end
        endcase
    end

    // One memory access per instruction
    assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite));

endmodule

// ==== src/regFile.sv ====
// Register file with two combinational read ports, one write port and hardwired x0
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  regIdxT rs1,
    input  regIdxT rs2,
    output xlenT   rdata1,
    output xlenT   rdata2,
    input  logic   we,
    input  regIdxT waddr,
    input  xlenT   wdata
);

    // x1 to x31 only
    xlenT regs [1:NUM_REGS-1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // Write address from the result stage must be resolved
    assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(waddr));

endmodule

// ==== src/aluExecute.sv ====
// Operand bypass, ALU, branch compare, target calculation and execute register
`timescale 1ns/1ps

module aluExecute import rvPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   decValid,
    input  xlenT   pc,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  funct3T funct3,
    input  xlenT   imm,
    input  aluOpE  aluOp,
    input  logic   aluSrcImm,
    input  logic   aluSrcPc,
    input  logic   regWrite,
    input  logic   memRead,
    input  logic   memWrite,
    input  logic   isBranch,
    input  logic   isJump,
    input  logic   isJalr,
    input  logic   illegalOp,
    input  xlenT   rdata1,
    input  xlenT   rdata2,
    input  logic   fwdWbValid,
    input  regIdxT fwdWbRd,
    input  xlenT   fwdWbData,
    output logic   exValid,
    output xlenT   exResult,
    output xlenT   exStoreData,
    output regIdxT exRd,
    output logic   exRegWrite,
    output logic   exMemRead,
    output logic   exMemWrite,
    output logic   redirect,
    output xlenT   redirectPc,
    output logic   illegal
);

    xlenT src1;
    xlenT src2;
    xlenT opA;
    xlenT opB;
    xlenT aluOut;
    xlenT result;
    xlenT target;
    logic brCond;
    logic taken;

    // Result stage holds the only producer not yet in the register file
    function automatic xlenT bypass(input regIdxT idx, input xlenT rfData);
        xlenT val;
        val = rfData;
        // Load data or ALU result from the result stage
        if ((idx != '0) && fwdWbValid && (fwdWbRd == idx))
        begin
            val = fwdWbData;
        end
        return val;
    endfunction

    always_comb
    begin
        src1 = bypass(rs1, rdata1);
        src2 = bypass(rs2, rdata2);
    end

    // Operand select
    assign opA = aluSrcPc ? pc : src1;
    assign opB = aluSrcImm ? imm : src2;

    // ALU
    always_comb
    begin
        case (aluOp)
            ALU_ADD:   aluOut = opA + opB;
            ALU_SUB:   aluOut = opA - opB;
            ALU_SLL:   aluOut = opA << opB[4:0];
            ALU_SLT:   aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluOut = {{(XLEN-1){1'b0}}, opA < opB};
            ALU_XOR:   aluOut = opA ^ opB;
            ALU_SRL:   aluOut = opA >> opB[4:0];
            ALU_SRA:   aluOut = xlenT'($signed(opA) >>> opB[4:0]);
            ALU_OR:    aluOut = opA | opB;
            ALU_AND:   aluOut = opA & opB;
            default:   aluOut = opB;
        endcase
    end

    // Link value for jumps
    assign result = isJump ? (pc + 32'd4) : aluOut;

    // Branch condition on the bypassed register values
    always_comb
    begin
        case (funct3)
            F3_BEQ:  brCond = (src1 == src2);
            F3_BNE:  brCond = (src1 != src2);
            F3_BLT:  brCond = ($signed(src1) < $signed(src2));
            F3_BGE:  brCond = ($signed(src1) >= $signed(src2));
            F3_BLTU: brCond = (src1 < src2);
            F3_BGEU: brCond = (src1 >= src2);
            default: brCond = 1'b0;
        endcase
    end

    assign taken = decValid && (isJump || (isBranch && brCond));

    // Branches add imm to pc and jumps take the ALU sum
    always_comb
    begin
        if (isBranch)
        begin
            target = pc + imm;
        end
        else if (isJalr)
        begin
            target = {aluOut[XLEN-1:1], 1'b0};
        end
        else
        begin
            target = aluOut;
        end
    end

    // Execute register control
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            redirect   <= 1'b0;
            illegal    <= 1'b0;
        end
        else
        begin
            exValid    <= decValid;
            exRegWrite <= decValid && regWrite;
            exMemRead  <= decValid && memRead;
            exMemWrite <= decValid && memWrite;
            redirect   <= taken;
            illegal    <= decValid && illegalOp;
        end
    end

    // Execute register payload
    always_ff @(posedge clk)
    begin
        exResult    <= result;
        exStoreData <= src2;
        exRd        <= rd;
        redirectPc  <= target;
    end

    // Slot behind a redirect is squashed and never redirects again
    assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect);

endmodule

// ==== src/memWriteback.sv ====
// Data memory, word load and store, result select and write-back register
`timescale 1ns/1ps

module memWriteback import rvPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   exValid,
    input  xlenT   exResult,
    input  xlenT   exStoreData,
    input  regIdxT exRd,
    input  logic   exRegWrite,
    input  logic   exMemRead,
    input  logic   exMemWrite,
    output logic   wbValid,
    output regIdxT wbRd,
    output xlenT   wbData,
    output logic   regWe,
    output regIdxT regWaddr,
    output xlenT   regWdata
);

    xlenT     dmem [DMEM_WORDS];
    dmemAddrT addr;
    xlenT     loadData;
    xlenT     resData;

    // Word index from byte address, low bits ignored
    assign addr = exResult[DMEM_AW+1:2];

    // Store at the clock edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (exValid && exMemWrite)
        begin
            dmem[addr] <= exStoreData;
        end
    end

    // Combinational load
    assign loadData = dmem[addr];
    assign resData  = exMemRead ? loadData : exResult;

    // Register-file write port, also the bypass source for execute
    assign regWe    = exValid && exRegWrite;
    assign regWaddr = exRd;
    assign regWdata = resData;

    // Write-back pulse only for real register writes
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wbValid <= 1'b0;
        end
        else
        begin
            wbValid <= regWe && (exRd != '0);
        end
    end

    always_ff @(posedge clk)
    begin
        wbRd   <= exRd;
        wbData <= resData;
    end

endmodule

// ==== src/rvCore.sv ====
// Core top level wiring decode, register file, execute and result stages
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   instrValid,
    input  instrT  instr,
    input  xlenT   instrPc,
    output logic   redirect,
    output xlenT   redirectPc,
    output logic   wbValid,
    output regIdxT wbRd,
    output xlenT   wbData,
    output logic   illegal
);

    // Decode to execute
    logic   decValid;
    xlenT   pc;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
    funct3T funct3;
    xlenT   imm;
    aluOpE  aluOp;
    logic   aluSrcImm;
    logic   aluSrcPc;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   isBranch;
    logic   isJump;
    logic   isJalr;
    logic   illegalOp;

    // Register file reads
    xlenT   rdata1;
    xlenT   rdata2;

    // Execute register
    logic   exValid;
    xlenT   exResult;
    xlenT   exStoreData;
    regIdxT exRd;
    logic   exRegWrite;
    logic   exMemRead;
    logic   exMemWrite;

    // Register write port, shared with the bypass
    logic   regWe;
    regIdxT regWaddr;
    xlenT   regWdata;

    instrDecode uDecode (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .flush      (redirect),
        .decValid   (decValid),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .funct3     (funct3),
        .imm        (imm),
        .aluOp      (aluOp),
        .aluSrcImm  (aluSrcImm),
        .aluSrcPc   (aluSrcPc),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .isBranch   (isBranch),
        .isJump     (isJump),
        .isJalr     (isJalr),
        .illegalOp  (illegalOp)
    );

    regFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (regWe),
        .waddr  (regWaddr),
        .wdata  (regWdata)
    );

    aluExecute uExecute (
        .clk         (clk),
        .rst         (rst),
        .decValid    (decValid),
        .pc          (pc),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .funct3      (funct3),
        .imm         (imm),
        .aluOp       (aluOp),
        .aluSrcImm   (aluSrcImm),
        .aluSrcPc    (aluSrcPc),
        .regWrite    (regWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .isBranch    (isBranch),
        .isJump      (isJump),
        .isJalr      (isJalr),
        .illegalOp   (illegalOp),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .fwdWbValid  (regWe),
        .fwdWbRd     (regWaddr),
        .fwdWbData   (regWdata),
        .exValid     (exValid),
        .exResult    (exResult),
        .exStoreData (exStoreData),
        .exRd        (exRd),
        .exRegWrite  (exRegWrite),
        .exMemRead   (exMemRead),
        .exMemWrite  (exMemWrite),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .illegal     (illegal)
    );

    memWriteback uResult (
        .clk         (clk),
        .rst         (rst),
        .exValid     (exValid),
        .exResult    (exResult),
        .exStoreData (exStoreData),
        .exRd        (exRd),
        .exRegWrite  (exRegWrite),
        .exMemRead   (exMemRead),
        .exMemWrite  (exMemWrite),
        .wbValid     (wbValid),
        .wbRd        (wbRd),
        .wbData      (wbData),
        .regWe       (regWe),
        .regWaddr    (regWaddr),
        .regWdata    (regWdata)
    );

endmodule

// ==== test/tbRvTests.svh ====
// Instruction encoders, reference ALU and branch rules, and the directed test tasks
`ifndef TB_RV_TESTS_SVH
`define TB_RV_TESTS_SVH

    // OP group, alt selects SUB and SRA
    function automatic instrT rType(input int f3, input int alt, input int rd,
                                    input int rs1, input int rs2);
        return {1'b0, alt[0], 5'b00000, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic instrT iType(input logic [6:0] opc, input int f3, input int rd,
                                    input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    // SW only
    function automatic instrT sType(input int imm, input int rs1, input int rs2);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic instrT bType(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instrT uType(input logic [6:0] opc, input int rd, input int hi);
        return {hi[19:0], rd[4:0], opc};
    endfunction

    function automatic instrT jType(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic instrT addi(input int rd, input int rs1, input int imm);
        return iType(OPC_OPIMM, 0, rd, rs1, imm);
    endfunction

    function automatic instrT lw(input int rd, input int rs1, input int imm);
        return iType(OPC_LOAD, 2, rd, rs1, imm);
    endfunction

    // RV32I integer semantics
    function automatic xlenT refAlu(input logic [2:0] f3, input logic alt,
                                    input xlenT a, input xlenT b);
        xlenT r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ({~a[31], a[30:0]} < {~b[31], b[30:0]}) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            // Arithmetic shift as logical shift plus sign fill
            3'b101:  r = (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input xlenT a, input xlenT b);
        logic lts;
        lts = {~a[31], a[30:0]} < {~b[31], b[30:0]};
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lts;
            3'b101:  return !lts;
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Any 32-bit constant through LUI plus ADDI
    task automatic loadReg(input int r, input xlenT v);
        xlenT hi;
        hi = v + 32'h800;
        step(uType(OPC_LUI, r, int'(hi[31:12])));
        step(addi(r, r, int'(v[11:0])));
    endtask

    task automatic resetAndX0();
        int cnt;
        step(addi(0, 0, 5));
        step(rType(0, 0, 2, 0, 0));
        drain();
        // Write-back three cycles after issue
        step(addi(1, 0, -3));
        idle();
        cnt = 1;
        while (!wbValid && cnt < 20)
        begin
            @(negedge clk);
            cnt++;
        end
        if (!wbValid)
        begin
            $display("Timeout waiting for the first write-back after reset");
        end
        checkEq("wbLatency", xlenT'(cnt), 32'd3);
        checkEq("x1", wbData, 32'hffff_fffd);
        drain();
    endtask

    task automatic aluOps();
        xlenT a;
        xlenT b;
        int   imm;
        for (int n = 0; n < 6; n++)
        begin
            a   = $random(seed);
            b   = $random(seed);
            imm = $random(seed);
            loadReg(5, a);
            loadReg(6, b);
            for (int f = 0; f < 8; f++)
            begin
                step(rType(f, 0, 7, 5, 6));
                step(iType(OPC_OPIMM, f, 8, 5, (f == 1 || f == 5) ? imm & 31 : imm));
            end
            // SUB, SRA and SRAI
            step(rType(0, 1, 9, 5, 6));
            step(rType(5, 1, 9, 5, 6));
            step(iType(OPC_OPIMM, 5, 10, 5, 32'h400 | (imm & 31)));
            drain();
        end
        // Most negative immediate, and SLTIU against all ones
        step(addi(11, 5, -2048));
        step(iType(OPC_OPIMM, 3, 12, 0, -1));
        drain();
    endtask

    task automatic dependentChains();
        step(addi(13, 0, 1));
        for (int i = 0; i < 6; i++)
        begin
            step(rType(0, 0, 13, 13, 13));
        end
        step(iType(OPC_OPIMM, 1, 14, 13, 3));
        step(rType(7, 0, 15, 14, 13));
        step(rType(0, 0, 16, 15, 14));
        step(rType(0, 1, 16, 16, 13));
        drain();
    endtask

    task automatic memoryAccess();
        loadReg(17, 32'h0000_0040);
        loadReg(18, 32'hdead_beef);
        step(sType(0, 17, 18));
        step(addi(19, 18, 1));
        step(sType(8, 17, 19));
        step(lw(20, 17, 0));
        step(lw(21, 17, 8));
        // Load-use pair
        step(rType(0, 0, 22, 21, 20));
        step(lw(23, 17, 4));
        step(sType(-4, 17, 22));
        step(lw(24, 17, -4));
        step(rType(0, 0, 25, 24, 24));
        drain();
    endtask

    task automatic controlFlow();
        loadReg(26, 32'hffff_ffff);
        loadReg(27, 32'd1);
        drain();
        pcNext = 32'h0000_0200;
        // Operand pairs give both outcomes for every condition
        for (int f = 0; f < 8; f++)
        begin
            if (f == 2 || f == 3)
            begin
                continue;
            end
            step(bType(f, 26, 27, 16));
            step(addi(28, 0, 99));
            step(addi(29, 29, 1));
            step(bType(f, 27, 26, -8));
            step(addi(28, 0, 77));
            step(addi(29, 29, 1));
            step(bType(f, 26, 26, 12));
            step(addi(28, 0, 55));
            step(addi(29, 29, 1));
        end
        drain();
        step(jType(30, 40));
        step(addi(28, 0, 11));
        step(rType(0, 0, 31, 30, 0));
        loadReg(24, 32'h0000_0301);
        step(iType(OPC_JALR, 0, 25, 24, 6));
        step(addi(28, 0, 12));
        step(addi(28, 25, 0));
        step(uType(OPC_LUI, 26, 32'habcde));
        step(uType(OPC_AUIPC, 27, 32'h12));
        step(uType(OPC_AUIPC, 27, -1));
        drain();
    endtask

    task automatic illegalOpcodes();
        // ECALL, all zeros, FENCE, then a custom opcode with a real rd
        step(32'h0000_0073);
        step(32'h0000_0000);
        step(32'h0000_000f);
        step(addi(28, 0, 5));
        step(32'h0000_028b);
        step(32'hffff_ffff);
        step(addi(28, 28, 1));
        drain();
    endtask

`endif

// ==== test/tbRvCore.sv ====
// Testbench top with clock, reset, DUT, reference model, scoreboard, checks and test sequence
`timescale 1ns/1ps

module tbRvCore import rvPkg::*; ();

    logic   clk;
    logic   rst;
    logic   instrValid;
    instrT  instr;
    xlenT   instrPc;
    logic   redirect;
    xlenT   redirectPc;
    logic   wbValid;
    regIdxT wbRd;
    xlenT   wbData;
    logic   illegal;

    // Result counters
    int     errors;
    int     checks;
    integer seed;

    // Reference architectural state
    xlenT   regModel [NUM_REGS];
    xlenT   memModel [DMEM_WORDS];

    // Expected DUT responses in program order
    regIdxT wbRdQ [$];
    xlenT   wbDataQ [$];
    xlenT   redirQ [$];
    int     illegalPending;

    // Fetch-side PC tracking
    xlenT   pcNext;
    xlenT   pendingTarget;
    logic   squashNext;

    rvCore DUT (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .illegal    (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Compare one value, report in hex on mismatch
    task automatic checkEq(input string name, input xlenT got, input xlenT exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Outputs are registered, so sample them on the falling edge
    always @(negedge clk)
    begin : scoreboard
        regIdxT expRd;
        xlenT   expData;
        xlenT   expPc;
        if (!rst && wbValid)
        begin
            if (wbRdQ.size() == 0)
            begin
                errors++;
                $display("Unexpected write-back to x%0d with data 0x%08h", wbRd, wbData);
            end
            else
            begin
                expRd   = wbRdQ.pop_front();
                expData = wbDataQ.pop_front();
                checkEq("wbRd", xlenT'(wbRd), xlenT'(expRd));
                checkEq("wbData", wbData, expData);
            end
        end
        if (!rst && redirect)
        begin
            if (redirQ.size() == 0)
            begin
                errors++;
                $display("Unexpected redirect to 0x%08h", redirectPc);
            end
            else
            begin
                expPc = redirQ.pop_front();
                checkEq("redirectPc", redirectPc, expPc);
            end
        end
        if (!rst && illegal)
        begin
            if (illegalPending == 0)
            begin
                errors++;
                $display("Unexpected illegal-instruction pulse");
            end
            else
            begin
                illegalPending--;
            end
        end
    end

    // Issue one instruction and apply its architectural effect to the model
    task automatic step(input instrT ins);
        logic [6:0] opc;
        logic [2:0] f3;
        xlenT       a;
        xlenT       b;
        xlenT       immI;
        xlenT       immS;
        xlenT       immB;
        xlenT       immJ;
        xlenT       ea;
        xlenT       res;
        xlenT       tgt;
        logic       wr;
        logic       tk;
        @(negedge clk);
        instrValid = 1'b1;
        instr      = ins;
        instrPc    = pcNext;
        // Wrong-path slot behind a taken branch never retires
        if (squashNext)
        begin
            squashNext = 1'b0;
            pcNext     = pendingTarget;
            return;
        end
        opc  = ins[6:0];
        f3   = ins[14:12];
        a    = regModel[ins[19:15]];
        b    = regModel[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        res  = '0;
        tgt  = '0;
        wr   = 1'b1;
        tk   = 1'b0;
        case (opc)
            OPC_LUI:
                res = {ins[31:12], 12'h000};
            OPC_AUIPC:
                res = pcNext + {ins[31:12], 12'h000};
            OPC_JAL:
            begin
                res = pcNext + 32'd4;
                tgt = pcNext + immJ;
                tk  = 1'b1;
            end
            OPC_JALR:
            begin
                res = pcNext + 32'd4;
                tgt = (a + immI) & ~32'd1;
                tk  = 1'b1;
            end
            OPC_BRANCH:
            begin
                wr  = 1'b0;
                tgt = pcNext + immB;
                tk  = branchTaken(f3, a, b);
            end
            OPC_LOAD:
            begin
                ea  = a + immI;
                res = memModel[ea[7:2]];
            end
            OPC_STORE:
            begin
                wr = 1'b0;
                ea = a + immS;
                memModel[ea[7:2]] = b;
            end
            OPC_OPIMM:
                res = refAlu(f3, (f3 == 3'b101) && ins[30], a, immI);
            OPC_OP:
                res = refAlu(f3, ins[30], a, b);
            default:
            begin
                wr = 1'b0;
                illegalPending++;
            end
        endcase
        if (wr && (ins[11:7] != 5'd0))
        begin
            regModel[ins[11:7]] = res;
            wbRdQ.push_back(ins[11:7]);
            wbDataQ.push_back(res);
        end
        pcNext = pcNext + 32'd4;
        if (tk)
        begin
            redirQ.push_back(tgt);
            pendingTarget = tgt;
            squashNext    = 1'b1;
        end
    endtask

    // Empty fetch slot
    task automatic idle();
        @(negedge clk);
        instrValid = 1'b0;
        if (squashNext)
        begin
            squashNext = 1'b0;
            pcNext     = pendingTarget;
        end
    endtask

    // Wait for all expected responses, then a little longer for stray pulses
    task automatic drain();
        int cnt;
        idle();
        cnt = 0;
        while ((wbRdQ.size() != 0 || redirQ.size() != 0 || illegalPending != 0) && cnt < 40)
        begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= 40)
        begin
            errors++;
            $display("Timeout: expected write-back, redirect or illegal pulse never arrived");
            wbRdQ.delete();
            wbDataQ.delete();
            redirQ.delete();
            illegalPending = 0;
        end
        repeat (3) @(negedge clk);
    endtask

    `include "tbRvTests.svh"

    initial
    begin
        seed           = 32'h10a2;
        errors         = 0;
        checks         = 0;
        illegalPending = 0;
        squashNext     = 1'b0;
        pcNext         = 32'h0000_0100;
        pendingTarget  = '0;
        instrValid     = 1'b0;
        instr          = '0;
        instrPc        = '0;
        foreach (regModel[i])
        begin
            regModel[i] = '0;
        end
        foreach (memModel[i])
        begin
            memModel[i] = '0;
        end
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        resetAndX0();
        aluOps();
        dependentChains();
        memoryAccess();
        controlFlow();
        illegalOpcodes();

        repeat (5) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+test
src/rvPkg.sv
src/instrDecode.sv
src/regFile.sv
src/aluExecute.sv
src/memWriteback.sv
src/rvCore.sv
test/tbRvCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tbRvCore
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
